/* verilog/rsz_params.svh */
`ifndef RSZ_PARAMS_SVH
`define RSZ_PARAMS_SVH

// Settings address of the packet size register
`define RSZ_BASE 128

// Samples per output packet out of reset
`define RSZ_DEFAULT_PKT_SIZE 8

// Header field widths
`define RSZ_SID_W 16
`define RSZ_SEQ_W 12

`endif

/* verilog/rsz_cfg_pkg.sv */
`default_nettype none

`include "rsz_params.svh"

package rsz_cfg_pkg;

  ////////////////////////////////////////
  // Settings bus
  ////////////////////////////////////////

  // One register write per strobe
  typedef struct packed {
    logic        stb;
    logic [7:0]  addr;
    logic [31:0] data;
  } set_bus_t;

  // Register map
  typedef enum logic [7:0] {
    REG_PKT_SIZE = 8'(`RSZ_BASE)
  } reg_addr_e;

endpackage

`default_nettype wire

/* verilog/rsz_stream_pkg.sv */
`default_nettype none

`include "rsz_params.svh"

package rsz_stream_pkg;

  ////////////////////////////////////////
  // Packet header word
  ////////////////////////////////////////

  // Stream id on top, padding at the bottom
  typedef struct packed {
    logic [`RSZ_SID_W-1:0]              sid;
    logic                               eob;
    logic [`RSZ_SEQ_W-1:0]              seq;
    logic [63-`RSZ_SID_W-`RSZ_SEQ_W-1:0] pad;
  } hdr_t;

  ////////////////////////////////////////
  // Samples between stages
  ////////////////////////////////////////

  typedef struct packed {
    logic [31:0]           data;
    logic [`RSZ_SID_W-1:0] sid;
    // Last sample of an input burst
    logic                  eob;
    // Last sample of an output packet
    logic                  pkt_last;
  } sample_t;

  // Unpacker FSM
  typedef enum logic [1:0] {
    UNP_HEADER,
    UNP_HIGH,
    UNP_LOW
  } unpack_state_e;

  // Packer FSM
  typedef enum logic [1:0] {
    PCK_HEADER,
    PCK_HIGH,
    PCK_LOW_OR_PAD
  } pack_state_e;

endpackage

`default_nettype wire

/* verilog/rsz_settings.sv */
`default_nettype none

`include "rsz_params.svh"

module rsz_settings (
  input  wire                      i_ce_clk,
  input  wire                      i_arst_n,
  input  wire rsz_cfg_pkg::set_bus_t i_set,
  output logic [15:0]              o_pkt_size
);

  logic        hit;
  logic [15:0] wr_size;

  // Write decode
  assign hit = i_set.stb && (i_set.addr == rsz_cfg_pkg::REG_PKT_SIZE);

  // Zero-sample packets make no sense, treat as one
  assign wr_size = (i_set.data[15:0] == 16'd0) ? 16'd1 : i_set.data[15:0];

  ////////////////////////////////////////
  // Packet size register
  ////////////////////////////////////////

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_pkt_size <= 16'(`RSZ_DEFAULT_PKT_SIZE);
    end else if (hit) begin
      o_pkt_size <= wr_size;
    end
  end

endmodule

`default_nettype wire

/* verilog/rsz_unpacker.sv */
`default_nettype none

`include "rsz_params.svh"

module rsz_unpacker (
  input  wire                     i_ce_clk,
  input  wire                     i_arst_n,
  input  wire [63:0]              i_tdata,
  input  wire                     i_tlast,
  input  wire                     i_tvalid,
  output logic                    o_tready,
  output rsz_stream_pkg::sample_t o_sample,
  output logic                    o_valid,
  input  wire                     i_ready
);

  rsz_stream_pkg::unpack_state_e state;
  rsz_stream_pkg::hdr_t          hdr;

  logic                  run_q;
  logic                  out_free;
  logic                  xfer;
  logic                  hdr_take;
  logic                  hi_load;
  logic                  lo_load;
  logic [`RSZ_SID_W-1:0] sid_q;
  logic                  eob_q;
  logic                  last_q;
  logic [31:0]           low_q;

  assign hdr = rsz_stream_pkg::hdr_t'(i_tdata);

  // Output register empty or drained this edge
  assign out_free = !o_valid || i_ready;

  // Headers need no room downstream, payload words do
  assign o_tready = run_q && ((state == rsz_stream_pkg::UNP_HEADER) ||
                              (state == rsz_stream_pkg::UNP_HIGH && out_free));

  assign xfer     = i_tvalid && o_tready;
  assign hdr_take = xfer && (state == rsz_stream_pkg::UNP_HEADER);
  assign hi_load  = xfer && (state == rsz_stream_pkg::UNP_HIGH);
  assign lo_load  = (state == rsz_stream_pkg::UNP_LOW) && out_free;

  ////////////////////////////////////////
  // FSM and valid
  ////////////////////////////////////////

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      run_q   <= 1'b0;
      state   <= rsz_stream_pkg::UNP_HEADER;
      o_valid <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (hi_load || lo_load) begin
        o_valid <= 1'b1;
      end else if (i_ready) begin
        o_valid <= 1'b0;
      end
      case (state)
        rsz_stream_pkg::UNP_HEADER: begin
          if (hdr_take) state <= rsz_stream_pkg::UNP_HIGH;
        end
        rsz_stream_pkg::UNP_HIGH: begin
          if (hi_load) state <= rsz_stream_pkg::UNP_LOW;
        end
        rsz_stream_pkg::UNP_LOW: begin
          // Back to header after the word carrying tlast
          if (lo_load) begin
            state <= last_q ? rsz_stream_pkg::UNP_HEADER : rsz_stream_pkg::UNP_HIGH;
          end
        end
        default: state <= rsz_stream_pkg::UNP_HEADER;
      endcase
    end
  end

  ////////////////////////////////////////
  // Header fields and sample data
  ////////////////////////////////////////

  always_ff @(posedge i_ce_clk) begin
    if (hdr_take) begin
      sid_q <= hdr.sid;
      eob_q <= hdr.eob;
    end
    if (hi_load) begin
      low_q             <= i_tdata[31:0];
      last_q            <= i_tlast;
      o_sample.data     <= i_tdata[63:32];
      o_sample.sid      <= sid_q;
      o_sample.eob      <= 1'b0;
      o_sample.pkt_last <= 1'b0;
    end else if (lo_load) begin
      o_sample.data     <= low_q;
      o_sample.sid      <= sid_q;
      // Only the final sample of an eob packet
      o_sample.eob      <= last_q && eob_q;
      o_sample.pkt_last <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* verilog/packet_resizer.sv */
`default_nettype none

module packet_resizer (
  input  wire                          i_ce_clk,
  input  wire                          i_arst_n,
  input  wire [15:0]                   i_pkt_size,
  input  wire rsz_stream_pkg::sample_t i_sample,
  input  wire                          i_valid,
  output logic                         o_ready,
  output rsz_stream_pkg::sample_t      o_sample,
  output logic                         o_valid,
  input  wire                          i_ready
);

  logic [15:0] cnt;
  logic [15:0] size_q;
  logic [15:0] cur_size;
  logic        take;
  logic        last;

  assign o_ready = !o_valid || i_ready;
  assign take    = i_valid && o_ready;

  // New size only at a packet boundary
  assign cur_size = (cnt == 16'd0) ? i_pkt_size : size_q;

  // Close on the size limit or at the end of a burst
  assign last = ((cnt + 16'd1) == cur_size) || i_sample.eob;

  ////////////////////////////////////////
  // Sample counter
  ////////////////////////////////////////

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      cnt     <= 16'd0;
      o_valid <= 1'b0;
    end else begin
      if (take) begin
        o_valid <= 1'b1;
        cnt     <= last ? 16'd0 : cnt + 16'd1;
      end else if (i_ready) begin
        o_valid <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Pipeline register
  ////////////////////////////////////////

  always_ff @(posedge i_ce_clk) begin
    if (take) begin
      if (cnt == 16'd0) begin
        size_q <= i_pkt_size;
      end
      o_sample          <= i_sample;
      o_sample.pkt_last <= last;
    end
  end

endmodule

`default_nettype wire

/* verilog/rsz_packer.sv */
`default_nettype none

`include "rsz_params.svh"

module rsz_packer (
  input  wire                          i_ce_clk,
  input  wire                          i_arst_n,
  input  wire rsz_stream_pkg::sample_t i_sample,
  input  wire                          i_valid,
  output logic                         o_ready,
  output logic [63:0]                  o_tdata,
  output logic                         o_tlast,
  output logic                         o_tvalid,
  input  wire                          i_tready
);

  rsz_stream_pkg::pack_state_e state;
  rsz_stream_pkg::hdr_t        hdr_word;

  logic [`RSZ_SEQ_W-1:0] seq_q;
  logic                  eob_prev_q;
  logic [31:0]           hi_q;
  logic                  hi_last_q;
  logic                  hi_eob_q;
  logic                  out_free;
  logic                  hdr_load;
  logic                  hi_take;
  logic                  pad_load;
  logic                  lo_take;

  assign out_free = !o_tvalid || i_tready;

  // The header waits on the first sample but does not consume it
  assign hdr_load = (state == rsz_stream_pkg::PCK_HEADER) && i_valid && out_free;
  assign hi_take  = (state == rsz_stream_pkg::PCK_HIGH) && i_valid;
  assign pad_load = (state == rsz_stream_pkg::PCK_LOW_OR_PAD) && hi_last_q && out_free;
  assign lo_take  = (state == rsz_stream_pkg::PCK_LOW_OR_PAD) && !hi_last_q &&
                    i_valid && out_free;

  assign o_ready = (state == rsz_stream_pkg::PCK_HIGH) ||
                   ((state == rsz_stream_pkg::PCK_LOW_OR_PAD) && !hi_last_q && out_free);

  // eob reflects how the previous packet closed
  assign hdr_word = '{sid: i_sample.sid, eob: eob_prev_q, seq: seq_q, pad: '0};

  ////////////////////////////////////////
  // FSM, sequence and valid
  ////////////////////////////////////////

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state      <= rsz_stream_pkg::PCK_HEADER;
      seq_q      <= '0;
      eob_prev_q <= 1'b0;
      o_tvalid   <= 1'b0;
    end else begin
      if (hdr_load || pad_load || lo_take) begin
        o_tvalid <= 1'b1;
      end else if (i_tready) begin
        o_tvalid <= 1'b0;
      end
      case (state)
        rsz_stream_pkg::PCK_HEADER: begin
          if (hdr_load) begin
            seq_q <= seq_q + 1'b1;
            state <= rsz_stream_pkg::PCK_HIGH;
          end
        end
        rsz_stream_pkg::PCK_HIGH: begin
          if (hi_take) state <= rsz_stream_pkg::PCK_LOW_OR_PAD;
        end
        rsz_stream_pkg::PCK_LOW_OR_PAD: begin
          if (pad_load) begin
            eob_prev_q <= hi_eob_q;
            state      <= rsz_stream_pkg::PCK_HEADER;
          end else if (lo_take && i_sample.pkt_last) begin
            eob_prev_q <= i_sample.eob;
            state      <= rsz_stream_pkg::PCK_HEADER;
          end else if (lo_take) begin
            state <= rsz_stream_pkg::PCK_HIGH;
          end
        end
        default: state <= rsz_stream_pkg::PCK_HEADER;
      endcase
    end
  end

  ////////////////////////////////////////
  // Word assembly
  ////////////////////////////////////////

  always_ff @(posedge i_ce_clk) begin
    if (hi_take) begin
      hi_q      <= i_sample.data;
      hi_last_q <= i_sample.pkt_last;
      hi_eob_q  <= i_sample.eob;
    end
    if (hdr_load) begin
      o_tdata <= hdr_word;
      o_tlast <= 1'b0;
    end else if (pad_load) begin
      // Odd packet, low half zero
      o_tdata <= {hi_q, 32'd0};
      o_tlast <= 1'b1;
    end else if (lo_take) begin
      o_tdata <= {hi_q, i_sample.data};
      o_tlast <= i_sample.pkt_last;
    end
  end

endmodule

`default_nettype wire

/* verilog/noc_block_packet_resizer.sv */
`default_nettype none

module noc_block_packet_resizer (
  input  wire                        i_ce_clk,
  input  wire                        i_arst_n,
  input  wire rsz_cfg_pkg::set_bus_t i_set,
  input  wire [63:0]                 i_s_tdata,
  input  wire                        i_s_tlast,
  input  wire                        i_s_tvalid,
  output logic                       o_s_tready,
  output logic [63:0]                o_m_tdata,
  output logic                       o_m_tlast,
  output logic                       o_m_tvalid,
  input  wire                        i_m_tready
);

  logic [15:0]             pkt_size;
  rsz_stream_pkg::sample_t unp_sample;
  logic                    unp_valid;
  logic                    unp_ready;
  rsz_stream_pkg::sample_t rsz_sample;
  logic                    rsz_valid;
  logic                    rsz_ready;

  ////////////////////////////////////////
  // Settings
  ////////////////////////////////////////

  rsz_settings settings0 (
    .i_ce_clk   (i_ce_clk),
    .i_arst_n   (i_arst_n),
    .i_set      (i_set),
    .o_pkt_size (pkt_size)
  );

  ////////////////////////////////////////
  // Unpack, resize, repack
  ////////////////////////////////////////

  rsz_unpacker unpacker0 (
    .i_ce_clk (i_ce_clk),
    .i_arst_n (i_arst_n),
    .i_tdata  (i_s_tdata),
    .i_tlast  (i_s_tlast),
    .i_tvalid (i_s_tvalid),
    .o_tready (o_s_tready),
    .o_sample (unp_sample),
    .o_valid  (unp_valid),
    .i_ready  (unp_ready)
  );

  packet_resizer resizer0 (
    .i_ce_clk   (i_ce_clk),
    .i_arst_n   (i_arst_n),
    .i_pkt_size (pkt_size),
    .i_sample   (unp_sample),
    .i_valid    (unp_valid),
    .o_ready    (unp_ready),
    .o_sample   (rsz_sample),
    .o_valid    (rsz_valid),
    .i_ready    (rsz_ready)
  );

  rsz_packer packer0 (
    .i_ce_clk (i_ce_clk),
    .i_arst_n (i_arst_n),
    .i_sample (rsz_sample),
    .i_valid  (rsz_valid),
    .o_ready  (rsz_ready),
    .o_tdata  (o_m_tdata),
    .o_tlast  (o_m_tlast),
    .o_tvalid (o_m_tvalid),
    .i_tready (i_m_tready)
  );

endmodule

`default_nettype wire

/* verification/rsz_checker.sv */
`default_nettype none

module rsz_checker (
  input  wire         i_clk,
  input  wire         i_arst_n,
  input  wire  [63:0] i_tdata,
  input  wire         i_tlast,
  input  wire         i_tvalid,
  input  wire         i_tready,
  input  wire  [64:0] i_exp_word,
  input  wire  [31:0] i_exp_count,
  output logic [31:0] o_rd_count,
  output logic [31:0] o_err_count
);

  logic [63:0] exp_data;
  logic        exp_last;

  // Head of the model queue, tlast on top
  assign exp_data = i_exp_word[63:0];
  assign exp_last = i_exp_word[64];

  ////////////////////////////////////////
  // Compare every output transfer
  ////////////////////////////////////////

  always @(posedge i_clk or negedge i_arst_n) begin : compare
    int bad;
    bad = 0;
    if (!i_arst_n) begin
      o_rd_count  <= '0;
      o_err_count <= '0;
    end else if (i_tvalid && i_tready) begin
      if (o_rd_count >= i_exp_count) begin
        $display("unexpected output word %h at time %0t, the model has nothing pending",
                 i_tdata, $time);
        bad = 1;
      end else begin
        if (i_tdata !== exp_data) begin
          $display("mismatch at time %0t: o_m_tdata expected %h got %h",
                   $time, exp_data, i_tdata);
          bad = bad + 1;
        end
        if (i_tlast !== exp_last) begin
          $display("mismatch at time %0t: o_m_tlast expected %b got %b",
                   $time, exp_last, i_tlast);
          bad = bad + 1;
        end
        o_rd_count <= o_rd_count + 32'd1;
      end
      o_err_count <= o_err_count + 32'(bad);
    end
  end

endmodule

`default_nettype wire

/* verification/rsz_props.sv */
`default_nettype none

module rsz_props (
  input wire        i_clk,
  input wire        i_arst_n,
  input wire [63:0] i_tdata,
  input wire        i_tlast,
  input wire        i_tvalid,
  input wire        i_tready,
  input wire        i_s_tready
);

  logic at_hdr;

  // Next word out is a header
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      at_hdr <= 1'b1;
    end else if (i_tvalid && i_tready) begin
      at_hdr <= i_tlast;
    end
  end

  ////////////////////////////////////////
  // Output stream rules
  ////////////////////////////////////////

  quiet_in_reset: assert property (@(posedge i_clk) !i_arst_n |-> (!i_tvalid && !i_s_tready))
    else $error("o_m_tvalid or o_s_tready high while reset is asserted");

  hold_on_stall: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_tvalid && !i_tready) |=> (i_tvalid && $stable(i_tdata) && $stable(i_tlast)))
    else $error("output word changed or dropped while stalled");

  payload_after_hdr: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_tvalid && at_hdr) |-> !i_tlast)
    else $error("header word carried tlast, packet has no payload");

endmodule

`default_nettype wire

/* verification/tb_packet_resizer.sv */
`default_nettype none

`include "rsz_params.svh"

module tb_packet_resizer;

  logic                  clk;
  logic                  arst_n;
  rsz_cfg_pkg::set_bus_t set_bus;
  logic [63:0]           s_tdata;
  logic                  s_tlast;
  logic                  s_tvalid;
  logic                  o_s_tready;
  logic [63:0]           m_tdata;
  logic                  m_tlast;
  logic                  m_tvalid;
  logic                  m_tready;

  logic [31:0] chk_rd;
  logic [31:0] chk_err;
  logic [64:0] exp_head;
  logic [64:0] exp_mem [0:2047];
  int          exp_wr = 0;

  // Input word stream and its samples for one burst
  logic [63:0] in_data [0:63];
  logic        in_last [0:63];
  int          in_n;
  logic [31:0] smp [0:63];
  int          n_smp;
  logic [`RSZ_SEQ_W-1:0] in_seq = '0;

  // Reference model state
  int                    mdl_size = `RSZ_DEFAULT_PKT_SIZE;
  logic [`RSZ_SEQ_W-1:0] mdl_seq = '0;
  logic                  mdl_eob_prev = 1'b0;
  int                    mdl_pkts = 0;

  logic [15:0] lfsr_state = 16'd26413;
  logic        gaps_on = 1'b0;
  int          cycles = 0;
  int          words_sent = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          err_mark = 0;
  int          pkt_mark = 0;

  noc_block_packet_resizer dut0 (
    .i_ce_clk   (clk),
    .i_arst_n   (arst_n),
    .i_set      (set_bus),
    .i_s_tdata  (s_tdata),
    .i_s_tlast  (s_tlast),
    .i_s_tvalid (s_tvalid),
    .o_s_tready (o_s_tready),
    .o_m_tdata  (m_tdata),
    .o_m_tlast  (m_tlast),
    .o_m_tvalid (m_tvalid),
    .i_m_tready (m_tready)
  );

  assign exp_head = exp_mem[chk_rd[10:0]];

  rsz_checker checker0 (
    .i_clk       (clk),
    .i_arst_n    (arst_n),
    .i_tdata     (m_tdata),
    .i_tlast     (m_tlast),
    .i_tvalid    (m_tvalid),
    .i_tready    (m_tready),
    .i_exp_word  (exp_head),
    .i_exp_count (exp_wr),
    .o_rd_count  (chk_rd),
    .o_err_count (chk_err)
  );

  bind noc_block_packet_resizer rsz_props props0 (
    .i_clk      (i_ce_clk),
    .i_arst_n   (i_arst_n),
    .i_tdata    (o_m_tdata),
    .i_tlast    (o_m_tlast),
    .i_tvalid   (o_m_tvalid),
    .i_tready   (i_m_tready),
    .i_s_tready (o_s_tready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Watchdog whose budget grows with the traffic accepted
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (s_tvalid && o_s_tready) words_sent <= words_sent + 1;
    if (cycles > 4 * words_sent + 200) begin
      $display("timeout after %0d cycles, %0d words sent, %0d expected words unchecked",
               cycles, words_sent, exp_wr - int'(chk_rd));
      $display("TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Random bits
  ////////////////////////////////////////

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 16'hB400;
    return n;
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // One clock with output ready gaps when enabled
  task automatic tick();
    logic [31:0] r;
    @(posedge clk);
    if (gaps_on) begin
      rand_bits(2, r);
      m_tready <= (r[1:0] != 2'd0);
    end else begin
      m_tready <= 1'b1;
    end
  endtask

  task automatic write_size(input logic [15:0] v);
    set_bus <= '{stb: 1'b1, addr: rsz_cfg_pkg::REG_PKT_SIZE, data: 32'(v)};
    tick();
    set_bus <= '0;
    mdl_size = (v == 16'd0) ? 1 : int'(v);
    tick();
  endtask

  // Split a burst into input packets with eob on the last header
  task automatic build_burst(input int n_words, input logic [15:0] sid);
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] r;
    int left;
    int plen;
    int k;
    rsz_stream_pkg::hdr_t h;
    in_n = 0;
    n_smp = 0;
    left = n_words;
    while (left > 0) begin
      rand_bits(2, r);
      plen = int'(r[1:0]) + 1;
      if (plen > left) plen = left;
      h = '{sid: sid, eob: (plen == left), seq: in_seq, pad: '0};
      in_seq = in_seq + 1'b1;
      in_data[in_n] = h;
      in_last[in_n] = 1'b0;
      in_n++;
      for (k = 0; k < plen; k++) begin
        rand_bits(32, hi);
        rand_bits(32, lo);
        in_data[in_n] = {hi, lo};
        in_last[in_n] = (k == plen - 1);
        in_n++;
        smp[n_smp] = hi;
        smp[n_smp + 1] = lo;
        n_smp += 2;
      end
      left -= plen;
    end
  endtask

  task automatic push_exp(input logic [63:0] d, input logic l);
    exp_mem[exp_wr] = {l, d};
    exp_wr = exp_wr + 1;
  endtask

  // Regroup samples into packets of mdl_size with a short one last
  task automatic model_burst(input logic [15:0] sid);
    int idx;
    int len;
    int j;
    logic [31:0] lo;
    rsz_stream_pkg::hdr_t h;
    idx = 0;
    while (idx < n_smp) begin
      len = (n_smp - idx < mdl_size) ? n_smp - idx : mdl_size;
      h = '{sid: sid, eob: mdl_eob_prev, seq: mdl_seq, pad: '0};
      push_exp(h, 1'b0);
      mdl_seq = mdl_seq + 1'b1;
      for (j = 0; j < len; j += 2) begin
        lo = (j + 1 < len) ? smp[idx + j + 1] : 32'd0;
        push_exp({smp[idx + j], lo}, (j + 2 >= len));
      end
      mdl_eob_prev = (idx + len == n_smp);
      mdl_pkts++;
      idx += len;
    end
  endtask

  task automatic send_stream();
    logic [31:0] r;
    int i;
    for (i = 0; i < in_n; i++) begin
      if (gaps_on) begin
        rand_bits(2, r);
        if (r[1:0] == 2'd0) begin
          s_tvalid <= 1'b0;
          tick();
        end
      end
      s_tdata  <= in_data[i];
      s_tlast  <= in_last[i];
      s_tvalid <= 1'b1;
      tick();
      while (!o_s_tready) tick();
    end
    s_tvalid <= 1'b0;
  endtask

  task automatic run_burst(input int n_words, input logic [15:0] sid);
    build_burst(n_words, sid);
    @(negedge clk);
    model_burst(sid);
    tick();
    send_stream();
  endtask

  task automatic wait_idle();
    while (chk_rd != exp_wr) tick();
    repeat (4) tick();
  endtask

  task automatic finish_test(input string name);
    int errs;
    wait_idle();
    errs = int'(chk_err) - err_mark;
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("test %0d %s: %0d packets, %0d errors", tests_run, name, mdl_pkts - pkt_mark, errs);
    err_mark = int'(chk_err);
    pkt_mark = mdl_pkts;
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin : main
    logic [31:0] r;
    logic [15:0] sid;
    int i;
    int missing;
    arst_n   = 1'b0;
    set_bus  = '0;
    s_tdata  = '0;
    s_tlast  = 1'b0;
    s_tvalid = 1'b0;
    m_tready = 1'b0;
    missing  = 0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    tick();

    // 20 samples at the reset size
    rand_bits(16, r);
    run_burst(10, r[15:0]);
    finish_test("default size");

    write_size(16'd1);
    rand_bits(16, r);
    run_burst(3, r[15:0]);
    finish_test("size 1");

    // Odd packets need padding
    write_size(16'd3);
    rand_bits(16, r);
    run_burst(5, r[15:0]);
    finish_test("size 3");

    write_size(16'd16);
    rand_bits(16, r);
    run_burst(12, r[15:0]);
    finish_test("size 16");

    write_size(16'd5);
    for (i = 0; i < 3; i++) begin
      rand_bits(16, r);
      sid = r[15:0];
      rand_bits(2, r);
      run_burst(int'(r[1:0]) + 1, sid);
    end
    finish_test("burst end");

    gaps_on = 1'b1;
    for (i = 0; i < 6; i++) begin
      rand_bits(3, r);
      write_size(16'(r[2:0]) + 16'd3);
      rand_bits(16, r);
      sid = r[15:0];
      rand_bits(3, r);
      run_burst(int'(r[2:0]) + 1, sid);
      wait_idle();
    end
    gaps_on = 1'b0;
    finish_test("back-pressure");

    write_size(16'd0);
    rand_bits(16, r);
    run_burst(2, r[15:0]);
    finish_test("size zero");

    // Anything still coming out now is extra
    repeat (20) tick();
    if (chk_rd != exp_wr) begin
      $display("%0d expected words never appeared on the output", exp_wr - int'(chk_rd));
      missing = 1;
    end
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
             int'(chk_err) + missing);
    if (chk_err == 0 && missing == 0 && tests_failed == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+verilog
verilog/rsz_cfg_pkg.sv
verilog/rsz_stream_pkg.sv
verilog/rsz_settings.sv
verilog/rsz_unpacker.sv
verilog/packet_resizer.sv
verilog/rsz_packer.sv
verilog/noc_block_packet_resizer.sv
verification/rsz_checker.sv
verification/rsz_props.sv
verification/tb_packet_resizer.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module tb_packet_resizer \
  && ./obj_dir/Vtb_packet_resizer > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -q "^TESTS PASSED$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
